//--- list.f
verilog/aluPkg.sv
verilog/busPkg.sv
verilog/aluIfs.sv
verilog/aluCore.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/axiLiteSlave.sv
verilog/aluTop.sv
dv/aluTop_sva.sv
dv/aluTb.sv

//--- dv/aluTb.sv
module aluTb;

	logic clk;
	logic rstN;
	logic [busPkg::ADDR_W-1:0] awAddr;
	logic awValid;
	logic awReady;
	logic [busPkg::AXI_DW-1:0] wData;
	logic [busPkg::AXI_DW/8-1:0] wStrb;
	logic wValid;
	logic wReady;
	logic [1:0] bResp;
	logic bValid;
	logic bReady;
	logic [busPkg::ADDR_W-1:0] arAddr;
	logic arValid;
	logic arReady;
	logic [busPkg::AXI_DW-1:0] rData;
	logic [1:0] rResp;
	logic rValid;
	logic rReady;

	int errors = 0;
	int maxWait = 64; // Cycles allowed for any one handshake
	logic [15:0] lfsr = 16'd34170;

	aluTop uut (.*);

	always #4 clk = ~clk;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic randBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], randBit()};
		end
		return v;
	endfunction

	function automatic logic [7:0] regAddr(input logic [1:0] idx);
		return {4'h0, idx, 2'b00};
	endfunction

	function automatic aluPkg::cmdWord_u arithCmd(input aluPkg::aluFunc_e f);
		aluPkg::cmdWord_u cw;
		cw = '0;
		cw.arith.func = f;
		cw.arith.dst = 2'(randBits(2));
		cw.arith.srcA = 2'(randBits(2));
		cw.arith.srcB = 2'(randBits(2));
		cw.arith.carrySel = randBit();
		cw.arith.uCin = randBit();
		return cw;
	endfunction

	function automatic aluPkg::cmdWord_u shiftCmd(input aluPkg::aluFunc_e f);
		aluPkg::cmdWord_u cw;
		cw = '0;
		cw.shift.shiftOp = 1'b1;
		cw.shift.func = f;
		cw.shift.dst = 2'(randBits(2));
		cw.shift.srcA = 2'(randBits(2));
		cw.shift.keepZero = randBit();
		return cw;
	endfunction

	task automatic reportTimeout(input string what);
		errors++;
		$display("Timeout at %0t while waiting for the %s handshake", $time, what);
	endtask

	// Random ready until the response handshake completes
	task automatic waitResp(input logic isWrite);
		logic got;
		got = 1'b0;
		for (int n = 0; n < maxWait && !got; n++) begin
			if (n > 0) begin
				@(posedge clk);
			end
			if (isWrite) begin
				bReady <= randBit();
			end else begin
				rReady <= randBit();
			end
			@(negedge clk);
			got = isWrite ? (bValid && bReady) : (rValid && rReady);
		end
		@(posedge clk);
		bReady <= 1'b0;
		rReady <= 1'b0;
		if (!got) begin
			reportTimeout(isWrite ? "write response" : "read data");
		end
	endtask

	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data);
		logic got;
		@(posedge clk);
		awAddr <= addr;
		wData <= data;
		awValid <= 1'b1;
		wValid <= 1'b1;
		got = 1'b0;
		for (int n = 0; n < maxWait && !got; n++) begin
			@(negedge clk);
			got = awReady && wReady;
		end
		@(posedge clk);
		awValid <= 1'b0;
		wValid <= 1'b0;
		if (got) begin
			waitResp(1'b1);
		end else begin
			reportTimeout("write accept");
		end
	endtask

	task automatic axiRead(input logic [7:0] addr);
		logic got;
		@(posedge clk);
		arAddr <= addr;
		arValid <= 1'b1;
		got = 1'b0;
		for (int n = 0; n < maxWait && !got; n++) begin
			@(negedge clk);
			got = arReady;
		end
		@(posedge clk);
		arValid <= 1'b0;
		if (got) begin
			waitResp(1'b0);
		end else begin
			reportTimeout("read address");
		end
	endtask

	// One fresh operand, the command, then destination and flags read back
	task automatic runCmd(input aluPkg::cmdWord_u cw);
		axiWrite(regAddr(2'(randBits(2))), randBits(32));
		axiWrite(busPkg::ADDR_CMD, {16'h0, cw});
		axiRead(regAddr(cw.arith.dst));
		axiRead(busPkg::ADDR_STATUS);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = '1;
		wValid = 1'b0;
		bReady = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		axiRead(busPkg::ADDR_REG0); // Reset values
		axiRead(busPkg::ADDR_STATUS);

		// Upper half of the write data is junk and must read back as 0
		for (int i = 0; i < 4; i++) begin
			axiWrite(regAddr(2'(i)), randBits(32));
		end
		for (int i = 0; i < 4; i++) begin
			axiRead(regAddr(2'(i)));
		end

		for (int n = 0; n < 8; n++) begin
			runCmd(arithCmd(aluPkg::FN_A));
			runCmd(arithCmd(aluPkg::FN_SUB));
			runCmd(arithCmd(aluPkg::FN_ADD));
			runCmd(arithCmd(aluPkg::FN_A_MINUS_ONE));
		end

		for (int n = 0; n < 4; n++) begin
			runCmd(arithCmd(aluPkg::FN_B));
			runCmd(arithCmd(aluPkg::FN_ZERO));
			runCmd(arithCmd(aluPkg::FN_NOT));
			runCmd(arithCmd(aluPkg::FN_XOR));
			runCmd(arithCmd(aluPkg::FN_AND));
			runCmd(arithCmd(aluPkg::FN_OR));
		end

		for (int n = 0; n < 8; n++) begin
			runCmd(shiftCmd(aluPkg::FN_SHIFT_RIGHT));
			runCmd(shiftCmd(aluPkg::FN_SHIFT_LEFT));
		end

		// Illegal codes, in either view
		runCmd(arithCmd(aluPkg::aluFunc_e'(5'h0A)));
		runCmd(arithCmd(aluPkg::FN_SHIFT_LEFT));
		runCmd(shiftCmd(aluPkg::FN_ADD));
		runCmd(shiftCmd(aluPkg::aluFunc_e'(5'h1F)));

		axiWrite(busPkg::ADDR_STATUS, randBits(32));
		axiWrite(8'h18, randBits(32));
		axiWrite(8'h02, randBits(32)); // Misaligned, so unmapped
		for (int i = 0; i < 4; i++) begin
			axiRead(regAddr(2'(i)));
		end
		axiRead(busPkg::ADDR_STATUS);
		axiRead(8'h20);

		repeat (4) @(posedge clk);
		$display("Errors: %0d testbench, %0d assertion", errors, uut.sva.failCount);
		if (errors == 0 && uut.sva.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- dv/aluTop_sva.sv
module aluTopSva (
	input logic clk,
	input logic rstN,
	input logic [busPkg::ADDR_W-1:0] awAddr,
	input logic awValid,
	input logic awReady,
	input logic [busPkg::AXI_DW-1:0] wData,
	input logic wValid,
	input logic wReady,
	input logic [1:0] bResp,
	input logic bValid,
	input logic bReady,
	input logic [busPkg::ADDR_W-1:0] arAddr,
	input logic arValid,
	input logic arReady,
	input logic [busPkg::AXI_DW-1:0] rData,
	input logic [1:0] rResp,
	input logic rValid,
	input logic rReady
);

	int failCount = 0;

	// Shadow of the working registers and flags
	logic [15:0] shReg [4];
	logic shC;
	logic shZ;

	logic wrAcc;
	logic rdAcc;
	logic isReg;
	logic isCmd;
	aluPkg::cmdWord_u cw;
	logic [15:0] opA;
	logic [15:0] opB;
	logic cinM;
	logic [16:0] wide;
	logic [15:0] mRes;
	logic mC;
	logic mZ;
	logic mLegal;
	logic [1:0] expB; // Expected write response of the last accepted write
	logic [31:0] expRData;
	logic [1:0] expRResp;

	assign wrAcc = awValid && awReady && wValid && wReady;
	assign rdAcc = arValid && arReady;
	assign isReg = awAddr inside {busPkg::ADDR_REG0, busPkg::ADDR_REG1,
		busPkg::ADDR_REG2, busPkg::ADDR_REG3};
	assign isCmd = (awAddr == busPkg::ADDR_CMD);

	// Expected outcome of the command on the write data bus
	always_comb begin
		cw = wData[15:0];
		opA = shReg[cw.arith.srcA]; // Source A sits in the same bits in both views
		opB = shReg[cw.arith.srcB];
		cinM = cw.arith.carrySel ? shC : cw.arith.uCin;
		wide = '0;
		mRes = '0;
		mC = shC;
		mLegal = 1'b1;
		if (cw.shift.shiftOp) begin
			case (cw.shift.func)
				aluPkg::FN_SHIFT_RIGHT: begin
					mRes = opA >> 1;
					mC = opA[0];
				end
				aluPkg::FN_SHIFT_LEFT: begin
					mRes = opA << 1;
					mC = opA[15];
				end
				default: mLegal = 1'b0;
			endcase
		end else begin
			case (cw.arith.func)
				aluPkg::FN_A: wide = opA + cinM;
				aluPkg::FN_SUB: wide = opA + {1'b0, ~opB} + cinM;
				aluPkg::FN_ADD: wide = opA + opB + cinM;
				aluPkg::FN_A_MINUS_ONE: wide = opA + 17'h0FFFF + cinM;
				aluPkg::FN_B: mRes = opB;
				aluPkg::FN_ZERO: mRes = '0;
				aluPkg::FN_NOT: mRes = ~opA;
				aluPkg::FN_XOR: mRes = opA ^ opB;
				aluPkg::FN_AND: mRes = opA & opB;
				aluPkg::FN_OR: mRes = opA | opB;
				default: mLegal = 1'b0;
			endcase
			if (cw.arith.func inside {aluPkg::FN_A, aluPkg::FN_SUB, aluPkg::FN_ADD,
					aluPkg::FN_A_MINUS_ONE}) begin
				mRes = wide[15:0];
				mC = wide[16];
			end
		end
		mZ = (cw.shift.shiftOp && cw.shift.keepZero) ? shZ : (mRes == 16'h0);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 4; i++) begin
				shReg[i] <= '0;
			end
			shC <= 1'b0;
			shZ <= 1'b0;
			expB <= busPkg::RESP_OKAY;
			expRData <= '0;
			expRResp <= busPkg::RESP_OKAY;
		end else begin
			if (wrAcc) begin
				if (isReg) begin
					shReg[awAddr[3:2]] <= wData[15:0];
					expB <= busPkg::RESP_OKAY;
				end else if (isCmd) begin
					expB <= mLegal ? busPkg::RESP_OKAY : busPkg::RESP_SLVERR;
					if (mLegal) begin
						shReg[cw.arith.dst] <= mRes;
						shC <= mC;
						shZ <= mZ;
					end
				end else begin
					expB <= busPkg::RESP_SLVERR; // STATUS and holes
				end
			end
			if (rdAcc) begin
				case (arAddr)
					busPkg::ADDR_REG0,
					busPkg::ADDR_REG1,
					busPkg::ADDR_REG2,
					busPkg::ADDR_REG3: begin
						expRData <= {16'h0, shReg[arAddr[3:2]]};
						expRResp <= busPkg::RESP_OKAY;
					end
					busPkg::ADDR_STATUS: begin
						expRData <= {30'h0, shZ, shC};
						expRResp <= busPkg::RESP_OKAY;
					end
					default: begin
						expRData <= '0;
						expRResp <= busPkg::RESP_SLVERR;
					end
				endcase
			end
		end
	end

	aRstQuiet: assert property (@(posedge clk)
		!rstN |-> !bValid && !rValid && !awReady && !wReady && !arReady)
	else begin
		failCount++;
		$error("A valid or ready output was high during reset");
	end

	aWrResp: assert property (@(posedge clk) disable iff (!rstN)
		wrAcc && !isCmd |=> bValid && bResp == expB)
	else begin
		failCount++;
		$error("ERROR %0t bValid,bResp got %b,%0h expected 1,%0h",
			$time, $sampled(bValid), $sampled(bResp), $sampled(expB));
	end

	// Command answer lands two cycles after the accept
	aCmdTiming: assert property (@(posedge clk) disable iff (!rstN)
		wrAcc && isCmd |=> !bValid ##1 bValid)
	else begin
		failCount++;
		$error("bValid did not rise exactly two cycles after a command accept");
	end

	aCmdResp: assert property (@(posedge clk) disable iff (!rstN)
		wrAcc && isCmd |-> ##2 bResp == expB)
	else begin
		failCount++;
		$error("ERROR %0t bResp got %0h expected %0h", $time, $sampled(bResp), $sampled(expB));
	end

	aBHold: assert property (@(posedge clk) disable iff (!rstN)
		bValid && !bReady |=> bValid && $stable(bResp))
	else begin
		failCount++;
		$error("Write response dropped or changed while bReady was low");
	end

	aRHold: assert property (@(posedge clk) disable iff (!rstN)
		rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
	else begin
		failCount++;
		$error("Read response dropped or changed while rReady was low");
	end

	aRData: assert property (@(posedge clk) disable iff (!rstN)
		rdAcc |=> rValid && rData == expRData)
	else begin
		failCount++;
		$error("ERROR %0t rData got %h expected %h", $time, $sampled(rData), $sampled(expRData));
	end

	aRResp: assert property (@(posedge clk) disable iff (!rstN)
		rdAcc |=> rResp == expRResp)
	else begin
		failCount++;
		$error("ERROR %0t rResp got %0h expected %0h", $time, $sampled(rResp), $sampled(expRResp));
	end

endmodule

bind aluTop aluTopSva sva (.*);

//--- verilog/aluTop.sv
module aluTop (
	input  logic clk,
	input  logic rstN,
	input  logic [busPkg::ADDR_W-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [busPkg::AXI_DW-1:0] wData,
	input  logic [busPkg::AXI_DW/8-1:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  logic [busPkg::ADDR_W-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [busPkg::AXI_DW-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady
);

	execIf execBus ();
	regIf regBus ();

	// Core operands and results
	logic [aluPkg::DATA_W-1:0] aluA;
	logic [aluPkg::DATA_W-1:0] aluB;
	aluPkg::aluFunc_e aluFunc;
	logic aluCin;
	logic aluEn;
	logic shiftEn;
	logic [aluPkg::DATA_W-1:0] aluY;
	logic aluCout;
	logic aluCoutValid;
	logic aluZero;
	logic aluLegal;

	axiLiteSlave slave (
		.clk(clk),
		.rstN(rstN),
		.awAddr(awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wData(wData),
		.wStrb(wStrb),
		.wValid(wValid),
		.wReady(wReady),
		.bResp(bResp),
		.bValid(bValid),
		.bReady(bReady),
		.arAddr(arAddr),
		.arValid(arValid),
		.arReady(arReady),
		.rData(rData),
		.rResp(rResp),
		.rValid(rValid),
		.rReady(rReady),
		.exec(execBus.master),
		.host(regBus.host)
	);

	execUnit exec (
		.clk(clk),
		.rstN(rstN),
		.ctl(execBus.slave),
		.rf(regBus.exec),
		.a(aluA),
		.b(aluB),
		.func(aluFunc),
		.cin(aluCin),
		.aluEn(aluEn),
		.shiftEn(shiftEn),
		.y(aluY),
		.cout(aluCout),
		.coutValid(aluCoutValid),
		.zero(aluZero),
		.legal(aluLegal)
	);

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.regs(regBus.regs)
	);

	aluCore core (
		.a(aluA),
		.b(aluB),
		.func(aluFunc),
		.cin(aluCin),
		.aluEn(aluEn),
		.shiftEn(shiftEn),
		.y(aluY),
		.cout(aluCout),
		.coutValid(aluCoutValid),
		.zero(aluZero),
		.legal(aluLegal)
	);

endmodule

//--- verilog/axiLiteSlave.sv
module axiLiteSlave (
	input  logic clk,
	input  logic rstN,
	input  logic [busPkg::ADDR_W-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [busPkg::AXI_DW-1:0] wData,
	input  logic [busPkg::AXI_DW/8-1:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  logic [busPkg::ADDR_W-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [busPkg::AXI_DW-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady,
	execIf.master exec,
	regIf.host host
);

	logic acceptQ;
	logic arReadyQ;
	logic bValidQ;
	logic [1:0] bRespQ;
	logic cmdOpen;
	logic startQ;
	aluPkg::cmdWord_u cmdQ;
	logic idle;
	logic wrAccept;
	logic rdAccept;
	logic wrIsReg;
	logic wrIsCmd;
	logic [1:0] cmdResp;
	logic [busPkg::AXI_DW-1:0] statusWord;
	logic [busPkg::AXI_DW-1:0] readWord;
	logic [1:0] readResp;

	assign awReady = acceptQ; // AW and W are taken together
	assign wReady = acceptQ;
	assign arReady = arReadyQ;

	// One transaction at a time, nothing new while a response is pending
	assign idle = !acceptQ && !arReadyQ && !bValidQ && !rValid && !cmdOpen;
	assign wrAccept = acceptQ && awValid && wValid;
	assign rdAccept = arReadyQ && arValid;

	always_comb begin
		wrIsReg = 1'b0;
		wrIsCmd = 1'b0;
		case (awAddr)
			busPkg::ADDR_REG0,
			busPkg::ADDR_REG1,
			busPkg::ADDR_REG2,
			busPkg::ADDR_REG3: wrIsReg = 1'b1;
			busPkg::ADDR_CMD: wrIsCmd = 1'b1;
			default: ; // STATUS and holes answer SLVERR
		endcase
	end

	always_comb begin
		statusWord = '0;
		statusWord[aluPkg::FLAG_C] = exec.carry;
		statusWord[aluPkg::FLAG_Z] = exec.zero;
		readWord = '0;
		readResp = busPkg::RESP_OKAY;
		case (arAddr)
			busPkg::ADDR_REG0,
			busPkg::ADDR_REG1,
			busPkg::ADDR_REG2,
			busPkg::ADDR_REG3: readWord = {{(busPkg::AXI_DW-aluPkg::DATA_W){1'b0}}, host.hostRdata};
			busPkg::ADDR_STATUS: readWord = statusWord;
			default: readResp = busPkg::RESP_SLVERR;
		endcase
	end

	// Host port, the read and write phases never overlap
	assign host.hostWe = wrAccept && wrIsReg;
	assign host.hostAddr = arReadyQ ? arAddr[aluPkg::REG_AW+1:2] : awAddr[aluPkg::REG_AW+1:2];
	assign host.hostWdata = wData[aluPkg::DATA_W-1:0];

	assign exec.start = startQ;
	assign exec.cmd = cmdQ;

	// Command response goes out in the done cycle
	assign cmdResp = exec.illegal ? busPkg::RESP_SLVERR : busPkg::RESP_OKAY;
	assign bValid = bValidQ || (cmdOpen && exec.done);
	assign bResp = bValidQ ? bRespQ : cmdResp;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			acceptQ <= 1'b0;
			arReadyQ <= 1'b0;
			bValidQ <= 1'b0;
			rValid <= 1'b0;
			cmdOpen <= 1'b0;
			startQ <= 1'b0;
			cmdQ <= '0;
		end else begin
			acceptQ <= 1'b0;
			arReadyQ <= 1'b0;
			startQ <= 1'b0;
			if (idle && awValid && wValid) begin
				acceptQ <= 1'b1; // Writes go first
			end else if (idle && arValid) begin
				arReadyQ <= 1'b1;
			end
			if (wrAccept) begin
				if (wrIsCmd) begin
					startQ <= 1'b1;
					cmdQ <= wData[aluPkg::DATA_W-1:0];
					cmdOpen <= 1'b1;
				end else begin
					bValidQ <= 1'b1;
				end
			end
			if (cmdOpen && exec.done) begin
				cmdOpen <= 1'b0;
				bValidQ <= !bReady; // Hold the response under back-pressure
			end else if (bValidQ && bReady) begin
				bValidQ <= 1'b0;
			end
			if (rdAccept) begin
				rValid <= 1'b1;
			end else if (rValid && rReady) begin
				rValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wrAccept && !wrIsCmd) begin
			bRespQ <= wrIsReg ? busPkg::RESP_OKAY : busPkg::RESP_SLVERR;
		end else if (cmdOpen && exec.done) begin
			bRespQ <= cmdResp;
		end
		if (rdAccept) begin
			rData <= readWord;
			rResp <= readResp;
		end
	end

endmodule

//--- verilog/execUnit.sv
module execUnit (
	input  logic clk,
	input  logic rstN,
	execIf.slave ctl,
	regIf.exec rf,
	output logic [aluPkg::DATA_W-1:0] a,
	output logic [aluPkg::DATA_W-1:0] b,
	output aluPkg::aluFunc_e func,
	output logic cin,
	output logic aluEn,
	output logic shiftEn,
	input  logic [aluPkg::DATA_W-1:0] y,
	input  logic cout,
	input  logic coutValid,
	input  logic zero,
	input  logic legal
);

	aluPkg::cmdWord_u cmd;
	logic isShift;
	logic keepZero;
	logic commit;
	logic carryQ;
	logic zeroQ;
	logic doneQ;
	logic illegalQ;

	assign cmd = ctl.cmd;
	assign isShift = cmd.arith.shiftOp; // Class bit sits in the same place in both views

	// Fields that both views keep in the same bits
	assign rf.rdAddrA = cmd.arith.srcA;
	assign rf.execAddr = cmd.arith.dst;
	assign func = cmd.arith.func;

	// Operand fetch per view
	always_comb begin
		if (isShift) begin
			rf.rdAddrB = '0;
			cin = 1'b0; // Shifts take no carry in
			keepZero = cmd.shift.keepZero;
		end else begin
			rf.rdAddrB = cmd.arith.srcB;
			cin = cmd.arith.carrySel ? carryQ : cmd.arith.uCin;
			keepZero = 1'b0;
		end
	end

	assign a = rf.rdA;
	assign b = rf.rdB;
	assign aluEn = !isShift;
	assign shiftEn = isShift;

	// Result lands on the edge that ends the start cycle
	assign commit = ctl.start && legal;
	assign rf.execWe = commit;
	assign rf.execWdata = y;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			carryQ <= 1'b0;
			zeroQ <= 1'b0;
			doneQ <= 1'b0;
			illegalQ <= 1'b0;
		end else begin
			doneQ <= ctl.start;
			if (ctl.start) begin
				illegalQ <= !legal;
			end
			if (commit) begin
				if (coutValid) begin
					carryQ <= cout;
				end
				if (!keepZero) begin
					zeroQ <= zero;
				end
			end
		end
	end

	assign ctl.done = doneQ;
	assign ctl.illegal = illegalQ; // Held until the next start
	assign ctl.carry = carryQ;
	assign ctl.zero = zeroQ;

endmodule

//--- verilog/regFile.sv
module regFile (
	input  logic clk,
	input  logic rstN,
	regIf.regs regs
);

	logic [aluPkg::DATA_W-1:0] regQ [aluPkg::NUM_REGS];

	// The bus slave keeps the two writers apart, exec wins if both fire
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < aluPkg::NUM_REGS; i++) begin
				regQ[i] <= '0;
			end
		end else if (regs.execWe) begin
			regQ[regs.execAddr] <= regs.execWdata;
		end else if (regs.hostWe) begin
			regQ[regs.hostAddr] <= regs.hostWdata;
		end
	end

	// Combinational read ports
	assign regs.rdA = regQ[regs.rdAddrA];
	assign regs.rdB = regQ[regs.rdAddrB];
	assign regs.hostRdata = regQ[regs.hostAddr];

endmodule

//--- verilog/aluCore.sv
module aluCore (
	input  logic [aluPkg::DATA_W-1:0] a,
	input  logic [aluPkg::DATA_W-1:0] b,
	input  aluPkg::aluFunc_e func,
	input  logic cin,
	input  logic aluEn,
	input  logic shiftEn,
	output logic [aluPkg::DATA_W-1:0] y,
	output logic cout,
	output logic coutValid,
	output logic zero,
	output logic legal
);

	logic [aluPkg::DATA_W-1:0] addB;
	logic [aluPkg::DATA_W:0] sum;
	logic [aluPkg::DATA_W-1:0] yAlu;
	logic [aluPkg::DATA_W-1:0] yShift;
	logic aluArith;
	logic aluLegal;
	logic shiftCout;
	logic shiftLegal;

	// Second adder operand, all arithmetic functions share one 17-bit adder
	always_comb begin
		addB = '0;
		aluArith = 1'b1;
		case (func)
			aluPkg::FN_A: addB = '0;
			aluPkg::FN_SUB: addB = ~b; // Carry out high means no borrow
			aluPkg::FN_ADD: addB = b;
			aluPkg::FN_A_MINUS_ONE: addB = '1;
			default: aluArith = 1'b0;
		endcase
	end

	assign sum = {1'b0, a} + {1'b0, addB} + {{aluPkg::DATA_W{1'b0}}, cin};

	always_comb begin
		yAlu = '0;
		aluLegal = 1'b1;
		case (func)
			aluPkg::FN_A,
			aluPkg::FN_SUB,
			aluPkg::FN_ADD,
			aluPkg::FN_A_MINUS_ONE: yAlu = sum[aluPkg::DATA_W-1:0];
			aluPkg::FN_B: yAlu = b;
			aluPkg::FN_ZERO: yAlu = '0;
			aluPkg::FN_NOT: yAlu = ~a;
			aluPkg::FN_XOR: yAlu = a ^ b;
			aluPkg::FN_AND: yAlu = a & b;
			aluPkg::FN_OR: yAlu = a | b;
			default: aluLegal = 1'b0;
		endcase
	end

	// One-bit shifter, the bit shifted out goes to carry
	always_comb begin
		yShift = '0;
		shiftCout = 1'b0;
		shiftLegal = 1'b1;
		case (func)
			aluPkg::FN_SHIFT_RIGHT: begin
				yShift = {1'b0, a[aluPkg::DATA_W-1:1]};
				shiftCout = a[0];
			end
			aluPkg::FN_SHIFT_LEFT: begin
				yShift = {a[aluPkg::DATA_W-2:0], 1'b0};
				shiftCout = a[aluPkg::DATA_W-1];
			end
			default: shiftLegal = 1'b0;
		endcase
	end

	// Result mux in place of the two output enables
	always_comb begin
		y = '0;
		cout = 1'b0;
		coutValid = 1'b0;
		legal = 1'b0;
		if (shiftEn) begin
			y = yShift;
			cout = shiftCout;
			coutValid = shiftLegal;
			legal = shiftLegal;
		end else if (aluEn) begin
			y = yAlu;
			cout = sum[aluPkg::DATA_W];
			coutValid = aluArith; // Logic functions keep the carry
			legal = aluLegal;
		end
	end

	assign zero = (y == '0);

endmodule

//--- verilog/aluIfs.sv
// Command launch from the bus slave to the execution unit
interface execIf;
	logic start;
	aluPkg::cmdWord_u cmd;
	logic done;
	logic illegal;
	logic carry;
	logic zero;

	modport master (output start, cmd, input done, illegal, carry, zero);
	modport slave (input start, cmd, output done, illegal, carry, zero);
endinterface

// Register file access, host port plus execution ports
interface regIf;
	logic hostWe;
	logic [aluPkg::REG_AW-1:0] hostAddr;
	logic [aluPkg::DATA_W-1:0] hostWdata;
	logic [aluPkg::DATA_W-1:0] hostRdata;
	logic [aluPkg::REG_AW-1:0] rdAddrA;
	logic [aluPkg::REG_AW-1:0] rdAddrB;
	logic [aluPkg::DATA_W-1:0] rdA;
	logic [aluPkg::DATA_W-1:0] rdB;
	logic execWe;
	logic [aluPkg::REG_AW-1:0] execAddr;
	logic [aluPkg::DATA_W-1:0] execWdata;

	modport host (output hostWe, hostAddr, hostWdata, input hostRdata);
	modport exec (output rdAddrA, rdAddrB, execWe, execAddr, execWdata, input rdA, rdB);
	modport regs (
		input hostWe, hostAddr, hostWdata, rdAddrA, rdAddrB, execWe, execAddr, execWdata,
		output hostRdata, rdA, rdB
	);
endinterface

//--- verilog/busPkg.sv
package busPkg;

	localparam int ADDR_W = 8;
	localparam int AXI_DW = 32;

	// Register map
	localparam logic [ADDR_W-1:0] ADDR_REG0 = 8'h00;
	localparam logic [ADDR_W-1:0] ADDR_REG1 = 8'h04;
	localparam logic [ADDR_W-1:0] ADDR_REG2 = 8'h08;
	localparam logic [ADDR_W-1:0] ADDR_REG3 = 8'h0C;
	localparam logic [ADDR_W-1:0] ADDR_CMD = 8'h10;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 8'h14; // Read only, C in bit 0 and Z in bit 1

	// Write and read response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- verilog/aluPkg.sv
package aluPkg;

	localparam int DATA_W = 16;
	localparam int NUM_REGS = 4;
	localparam int REG_AW = 2;

	// Bit positions in the status word
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;

	// Function codes, any other value is illegal
	typedef enum logic [4:0] {
		FN_A           = 5'h00,
		FN_B           = 5'h01,
		FN_SUB         = 5'h02,
		FN_ADD         = 5'h03,
		FN_A_MINUS_ONE = 5'h04,
		FN_ZERO        = 5'h05,
		FN_NOT         = 5'h06,
		FN_XOR         = 5'h07,
		FN_AND         = 5'h08,
		FN_OR          = 5'h09,
		FN_SHIFT_RIGHT = 5'h10, // Bit 0 picks the shift direction
		FN_SHIFT_LEFT  = 5'h11
	} aluFunc_e;

	typedef struct packed {
		logic shiftOp; // Class bit, low for this view
		aluFunc_e func;
		logic [REG_AW-1:0] dst;
		logic [REG_AW-1:0] srcA;
		logic [REG_AW-1:0] srcB;
		logic carrySel; // Take cin from the stored carry flag
		logic uCin; // Microcode carry-in
		logic [1:0] rsvd;
	} arithCmd_t;

	typedef struct packed {
		logic shiftOp; // Class bit, high for this view
		aluFunc_e func;
		logic [REG_AW-1:0] dst;
		logic [REG_AW-1:0] srcA;
		logic keepZero; // Shift through carry leaves Z alone
		logic [4:0] rsvd;
	} shiftCmd_t;

	typedef union packed {
		arithCmd_t arith;
		shiftCmd_t shift;
	} cmdWord_u;

endpackage
